// ==== sim.f ====
hdl/sdram_pkg.sv
hdl/sdram_req_decode.sv
hdl/sdram_bank.sv
hdl/sdram_cmd_arbiter.sv
hdl/sdram_rd_assemble.sv
hdl/sdram_ctrl_top.sv
tests/sdram_model.sv
tests/tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sdram_ctrl import sdram_pkg::*; ();

    localparam int RD_LAT   = CAS_LAT + BURST + 1;   // ack to rd_valid
    localparam int N_PER    = 50;                    // random accesses per client
    localparam int N_ACCESS = 6 + 4 + 4 * NBANK + 4 + NBANK * N_PER;
    localparam int MAX_CYC  = 40 * N_ACCESS + 16 + 100;
    localparam int WAIT_LIM = 200;                   // cycles for one ack or one drain

    typedef struct packed {
        logic             wr;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [DW-1:0]    wd;
    } acc_t;

    typedef struct packed {
        logic [1:0]          bank;
        logic [BURST*DW-1:0] data;
        logic [31:0]         cyc;   // cycle of the ack
    } rd_exp_t;

    logic                clk = 1'b0;
    logic                rst;
    client_req_t         req [NBANK];
    logic [NBANK-1:0]    ack;
    logic [NBANK-1:0]    rd_valid;
    logic [BURST*DW-1:0] rdata;
    sdram_pins_t         pins;
    logic [DW-1:0]       dq_in;
    logic                model_fault;

    logic [DW-1:0] shadow [logic [ADDR_W-1:0]];   // every word written so far
    rd_exp_t       pend_q [$];                    // reads in issue order
    acc_t          stim [NBANK][N_PER];
    int            cyc = 0;
    int            errors = 0;
    int            checks = 0;
    int            tests = 0;
    int            failed = 0;
    int            seed;
    int            mark;

    always #2 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    sdram_ctrl_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .rd_valid (rd_valid),
        .rdata    (rdata),
        .pins     (pins),
        .dq_in    (dq_in)
    );

    sdram_model mem0 (
        .clk   (clk),
        .pins  (pins),
        .dq    (dq_in),
        .fault (model_fault)
    );

    task automatic check_equal(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(string msg);
        errors++;
        $display("t=%0t: %s", $time, msg);
    endtask

    // contents of a location never written
    function automatic logic [DW-1:0] power_up_word(logic [ADDR_W-1:0] a);
        return a[DW-1:0] ^ {a[ADDR_W-1:DW], a[ADDR_W-1:DW]};
    endfunction

    // four consecutive columns from an aligned start, first word lowest
    function automatic logic [BURST*DW-1:0] ref_burst(logic [ADDR_W-1:0] a);
        logic [BURST*DW-1:0] r;
        logic [ADDR_W-1:0]   w;
        for (int k = 0; k < BURST; k++) begin
            w = a + ADDR_W'(k);
            r[k*DW +: DW] = shadow.exists(w) ? shadow[w] : power_up_word(w);
        end
        return r;
    endfunction

    function automatic acc_t make_access(logic wr, logic [ROW_W-1:0] row,
                                         logic [COL_W-1:0] col, logic [DW-1:0] wd);
        return '{wr: wr, row: row, col: col, wd: wd};
    endfunction

    function automatic acc_t rand_access();
        int   r;
        acc_t s;
        r     = $random(seed);
        s.wr  = r[8];
        s.row = 13'(r[1:0]);      // four rows per bank, plenty of misses
        s.col = 9'(r[7:4]);
        if (!s.wr)
            s.col[1:0] = 2'b00;   // bursts start on a group of four
        s.wd  = r[31:16];
        return s;
    endfunction

    // drive one request on the falling edge and hold it until ack
    task automatic access(int c, acc_t s);
        logic [ADDR_W-1:0] a;
        int                n;
        a = {2'(c), s.row, s.col};
        n = 0;
        @(negedge clk);
        req[c] = '{rd: !s.wr, wr: s.wr, addr: a, wdata: s.wd};
        do begin
            @(negedge clk);
            n++;
        end while (!ack[c] && n < WAIT_LIM);
        if (!ack[c])
            report_failure($sformatf("client %0d got no ack within %0d cycles", c, WAIT_LIM));
        else if (s.wr)
            shadow[a] = s.wd;
        else
            pend_q.push_back('{bank: 2'(c), data: ref_burst(a), cyc: cyc});
    endtask

    task automatic release_req(int c);
        @(negedge clk);
        req[c] = '0;
    endtask

    task automatic play(int c, int n);
        for (int i = 0; i < n; i++)
            access(c, stim[c][i]);
        release_req(c);
    endtask

    task automatic play_all(int n);
        fork
            play(0, n);
            play(1, n);
            play(2, n);
            play(3, n);
        join
    endtask

    // wait for outstanding bursts, then one line for the test
    task automatic end_test(string name, int start_errors);
        int n;
        n = 0;
        while (pend_q.size() != 0 && n < WAIT_LIM) begin
            @(negedge clk);
            n++;
        end
        if (pend_q.size() != 0) begin
            report_failure($sformatf("%0d reads never got their rd_valid", pend_q.size()));
            pend_q.delete();
        end
        tests++;
        if (errors != start_errors)
            failed++;
        $display("test %0d %s: %s", tests, name, (errors == start_errors) ? "ok" : "failed");
    endtask

    // every rd_valid against the oldest outstanding read
    always @(negedge clk) begin
        rd_exp_t          e;
        logic [NBANK-1:0] onehot;
        if (!rst && rd_valid != '0) begin
            if (pend_q.size() == 0) begin
                report_failure("rd_valid with no read outstanding");
            end else begin
                e      = pend_q.pop_front();
                onehot = '0;
                onehot[e.bank] = 1'b1;
                check_equal("rd_valid to the requesting client", 64'(rd_valid), 64'(onehot));
                check_equal("read data", rdata, e.data);
                check_equal("ack to rd_valid cycles", 64'(cyc - int'(e.cyc)), 64'(RD_LAT));
            end
        end
    end

    initial begin
        wait (cyc >= MAX_CYC);
        $display("timeout: run stopped after %0d cycles", cyc);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed = 26719;
        rst  = 1'b1;
        for (int c = 0; c < NBANK; c++)
            req[c] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mark = errors;
        for (int i = 0; i < BURST; i++)
            access(1, make_access(1'b1, 13'd5, 9'(8 + i), 16'(16'h1100 + i)));
        access(1, make_access(1'b0, 13'd5, 9'd8, 16'h0));
        access(1, make_access(1'b0, 13'd5, 9'd12, 16'h0));   // untouched columns
        release_req(1);
        end_test("write then read in one row", mark);

        mark = errors;
        access(2, make_access(1'b1, 13'd10, 9'd0, 16'hA0A0));
        access(2, make_access(1'b1, 13'd11, 9'd0, 16'hB0B0));   // miss, same column
        access(2, make_access(1'b0, 13'd10, 9'd0, 16'h0));      // back to the old row
        access(2, make_access(1'b0, 13'd11, 9'd0, 16'h0));
        release_req(2);
        end_test("row miss in one bank", mark);

        mark = errors;
        for (int c = 0; c < NBANK; c++) begin
            stim[c][0] = make_access(1'b1, 13'(20 + c), 9'd0, 16'(16'hC000 + c));
            stim[c][1] = make_access(1'b1, 13'(20 + c), 9'd1, 16'(16'hC100 + c));
            stim[c][2] = make_access(1'b0, 13'(20 + c), 9'd0, 16'h0);
            stim[c][3] = make_access(1'b0, 13'(20 + c), 9'd4, 16'h0);
        end
        play_all(4);
        end_test("all four banks at once", mark);

        mark = errors;
        for (int i = 0; i < 4; i++)
            access(3, make_access(1'b0, 13'd23, 9'(4 * i), 16'h0));   // row 23 still open
        release_req(3);
        end_test("back to back row hit reads", mark);

        mark = errors;
        for (int c = 0; c < NBANK; c++)
            for (int i = 0; i < N_PER; i++)
                stim[c][i] = rand_access();
        play_all(N_PER);
        end_test("random mixed accesses", mark);

        if (model_fault)
            report_failure("SDRAM model saw a command for a bank in the wrong state");
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tests/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model import sdram_pkg::*; (
    input  logic          clk,
    input  sdram_pins_t   pins,
    output logic [DW-1:0] dq,
    output logic          fault     // sticky, a command hit a bank in the wrong state
);

    localparam int PIPE_N = CAS_LAT + BURST;

    logic [DW-1:0]    mem [logic [ADDR_W-1:0]];           // sparse, written words only
    logic [ROW_W-1:0] row [NBANK] = '{default: '0};       // open row per bank
    logic             act [NBANK] = '{default: 1'b0};
    logic [DW-1:0]    pipe [PIPE_N] = '{default: '0};     // read words queued for dq, slot 0 next
    logic [DW-1:0]    dq_r = '0;
    bit               bad = 1'b0;

    assign dq    = dq_r;
    assign fault = bad;

    // power-up contents, a different word for every address
    function automatic logic [DW-1:0] fill_word(logic [ADDR_W-1:0] a);
        return a[DW-1:0] ^ {a[ADDR_W-1:DW], a[ADDR_W-1:DW]};
    endfunction

    function automatic logic [DW-1:0] read_word(logic [ADDR_W-1:0] a);
        if (mem.exists(a))
            return mem[a];
        return fill_word(a);
    endfunction

    always @(posedge clk) begin
        logic [ADDR_W-1:0] adr;
        adr = {pins.ba, row[pins.ba], pins.a[COL_W-1:0]};
        for (int i = 0; i < PIPE_N - 1; i++)
            pipe[i] = pipe[i+1];
        pipe[PIPE_N-1] = '0;
        case (pins.cmd)
            CMD_ACTIVE: begin
                if (act[pins.ba])
                    bad = 1'b1;              // no precharge before this activate
                act[pins.ba] = 1'b1;
                row[pins.ba] = pins.a;
            end
            CMD_PRECHARGE: act[pins.ba] = 1'b0;   // a10 low, one bank
            CMD_WRITE: begin
                if (!act[pins.ba] || !pins.dq_oe)
                    bad = 1'b1;
                mem[adr] = pins.dq_out;
            end
            CMD_READ: begin
                if (!act[pins.ba])
                    bad = 1'b1;
                // sequential burst, wraps inside its aligned group of four
                for (int k = 0; k < BURST; k++)
                    pipe[CAS_LAT-1+k] = read_word({adr[ADDR_W-1:2], adr[1:0] + 2'(k)});
            end
            default: ;
        endcase
        dq_r <= pipe[0];   // first word sampled CAS_LAT edges after the READ
    end

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
`timescale 1ns/1ps

module sdram_ctrl_top import sdram_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  client_req_t         req [NBANK],
    output logic [NBANK-1:0]    ack,
    output logic [NBANK-1:0]    rd_valid,
    output logic [BURST*DW-1:0] rdata,
    output sdram_pins_t         pins,
    input  logic [DW-1:0]       dq_in
);

    bank_req_t        breq [NBANK];
    bank_cmd_t        bcmd [NBANK];
    logic [NBANK-1:0] grant;
    logic             rd_issue;
    logic [1:0]       rd_bank;

    // client c is wired to bank c
    for (genvar b = 0; b < NBANK; b++) begin : g_bank
        sdram_req_decode u_dec (
            .clk    (clk),
            .rst    (rst),
            .req    (req[b]),
            .accept (ack[b]),
            .breq   (breq[b])
        );

        sdram_bank u_bank (
            .clk    (clk),
            .rst    (rst),
            .breq   (breq[b]),
            .grant  (grant[b]),
            .bcmd   (bcmd[b]),
            .accept (ack[b])     // ack goes out with the READ/WRITE
        );

        a_own_bank: assert property (@(posedge clk) disable iff (rst)
            (req[b].rd || req[b].wr) |-> req[b].addr[ADDR_W-1 -: BA_W] == BA_W'(b));
    end

    sdram_cmd_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .bcmd     (bcmd),
        .grant    (grant),
        .pins     (pins),
        .rd_issue (rd_issue),
        .rd_bank  (rd_bank)
    );

    sdram_rd_assemble u_rd (
        .clk      (clk),
        .rst      (rst),
        .rd_issue (rd_issue),
        .rd_bank  (rd_bank),
        .dq_in    (dq_in),
        .rd_valid (rd_valid),
        .rdata    (rdata)
    );

endmodule

// ==== hdl/sdram_rd_assemble.sv ====
`timescale 1ns/1ps

module sdram_rd_assemble import sdram_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_issue,
    input  logic [1:0]            rd_bank,
    input  logic [DW-1:0]         dq_in,
    output logic [NBANK-1:0]      rd_valid,
    output logic [BURST*DW-1:0]   rdata
);

    typedef struct packed {
        logic       v;
        logic [1:0] bank;
    } tag_t;

    tag_t                q [RD_PIPE];  // READ tags waiting for their data
    logic [DW-1:0]       dq_q;         // dq input register
    logic [BURST*DW-1:0] sh;
    logic                busy;
    logic [1:0]          beat;
    logic [1:0]          cur_bank;
    logic                start;

    assign start = q[RD_PIPE-1].v;   // first word sits in dq_q now

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < RD_PIPE; i++)
                q[i] <= '0;
            busy     <= 1'b0;
            beat     <= 2'd0;
            cur_bank <= 2'd0;
            rd_valid <= '0;
        end else begin
            q[0] <= '{v: rd_issue, bank: rd_bank};
            for (int i = 1; i < RD_PIPE; i++)
                q[i] <= q[i-1];
            rd_valid <= '0;
            if (start) begin
                busy     <= 1'b1;
                beat     <= 2'd1;
                cur_bank <= q[RD_PIPE-1].bank;
            end else if (busy) begin
                beat <= beat + 2'd1;
                if (beat == 2'(BURST - 1)) begin   // last word in
                    busy               <= 1'b0;
                    rd_valid[cur_bank] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        dq_q <= dq_in;
        if (start || busy)
            sh <= {dq_q, sh[BURST*DW-1:DW]};     // first word ends up lowest
        if (busy && beat == 2'(BURST - 1))
            rdata <= {dq_q, sh[BURST*DW-1:DW]};
    end

    // arbiter spacing must keep bursts from overlapping
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

// ==== hdl/sdram_cmd_arbiter.sv ====
`timescale 1ns/1ps

module sdram_cmd_arbiter import sdram_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  bank_cmd_t        bcmd [NBANK],
    output logic [NBANK-1:0] grant,
    output sdram_pins_t      pins,
    output logic             rd_issue,
    output logic [1:0]       rd_bank
);

    logic [1:0]       last;      // last bank granted
    logic [2:0]       rrd_cnt;   // blocks ACTIVE while nonzero
    logic [2:0]       dq_cnt;    // dq reservation left by the last READ
    logic [NBANK-1:0] elig;
    logic             found;
    logic [1:0]       sel;

    // may each bank's command go this cycle
    always_comb begin
        logic ok;
        for (int b = 0; b < NBANK; b++) begin
            case (bcmd[b].cmd)
                CMD_ACTIVE:          ok = (rrd_cnt == 3'd0);
                CMD_READ, CMD_WRITE: ok = bcmd[b].is_rd ? (dq_cnt <= 3'(RD_REOPEN))
                                                        : (dq_cnt == 3'd0);
                default:             ok = 1'b1;   // precharge never waits
            endcase
            elig[b] = bcmd[b].valid && ok;
        end
    end

    // round robin search from one past the last grant
    always_comb begin
        logic [1:0] idx;
        found = 1'b0;
        sel   = last;
        for (int i = 1; i <= NBANK; i++) begin
            idx = last + 2'(i);
            if (!found && elig[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found)
            grant[sel] = 1'b1;
    end

    always_comb begin
        pins.cmd    = CMD_NOP;
        pins.ba     = sel;
        pins.a      = bcmd[sel].a;
        pins.dq_out = bcmd[sel].wdata;
        pins.dq_oe  = 1'b0;
        if (found) begin
            pins.cmd   = bcmd[sel].cmd;
            pins.dq_oe = (bcmd[sel].cmd == CMD_WRITE);  // write data goes with the command
        end
    end

    assign rd_issue = found && bcmd[sel].cmd == CMD_READ && bcmd[sel].is_rd;
    assign rd_bank  = sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last    <= 2'(NBANK - 1);   // bank 0 first
            rrd_cnt <= 3'd0;
            dq_cnt  <= 3'd0;
        end else begin
            if (found)
                last <= sel;
            if (found && bcmd[sel].cmd == CMD_ACTIVE)
                rrd_cnt <= 3'(T_RRD - 1);
            else if (rrd_cnt != 3'd0)
                rrd_cnt <= rrd_cnt - 3'd1;
            if (rd_issue)
                dq_cnt <= 3'(DQ_HOLD);
            else if (dq_cnt != 3'd0)
                dq_cnt <= dq_cnt - 3'd1;
        end
    end

    // no ACTIVE on the pins right behind another ACTIVE (tRRD of 2)
    a_trrd_pins: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == CMD_ACTIVE |=> pins.cmd != CMD_ACTIVE);

endmodule

// ==== hdl/sdram_bank.sv ====
`timescale 1ns/1ps

module sdram_bank import sdram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bank_req_t breq,
    input  logic      grant,
    output bank_cmd_t bcmd,
    output logic      accept
);

    logic [3:0]       st, st_nx;    // one-hot
    logic [ROW_W-1:0] open_row;
    logic             row_open;
    logic [2:0]       cnt;          // tRP / tRCD countdown
    logic             load;         // present a new command next cycle
    sdram_cmd_e       cmd_nx;
    sdram_cmd_e       rw_cmd;
    logic             pend;
    logic             row_hit;
    logic             wait_done;

    // registered command toward the arbiter
    logic             valid_q;
    sdram_cmd_e       cmd_q;
    logic [ROW_W-1:0] a_q;
    logic             is_rd_q;
    logic [DW-1:0]    wdata_q;

    assign pend      = breq.rd | breq.wr;
    assign row_hit   = row_open && (open_row == breq.row);
    assign rw_cmd    = breq.rd ? CMD_READ : CMD_WRITE;
    assign wait_done = !valid_q && (cnt <= 3'd1);  // granted and the gap is over
    assign accept    = grant && st[S_ISSUE];

    always_comb begin
        st_nx  = st;
        load   = 1'b0;
        cmd_nx = CMD_NOP;
        if (st[S_IDLE] && pend) begin
            load = 1'b1;
            if (row_hit) begin               // straight to the column command
                st_nx  = 4'b1 << S_ISSUE;
                cmd_nx = rw_cmd;
            end else if (row_open) begin     // wrong row, close it first
                st_nx  = 4'b1 << S_PRE;
                cmd_nx = CMD_PRECHARGE;
            end else begin
                st_nx  = 4'b1 << S_ACT;
                cmd_nx = CMD_ACTIVE;
            end
        end
        if (st[S_PRE] && wait_done) begin
            st_nx  = 4'b1 << S_ACT;
            load   = 1'b1;
            cmd_nx = CMD_ACTIVE;
        end
        if (st[S_ACT] && wait_done) begin
            st_nx  = 4'b1 << S_ISSUE;
            load   = 1'b1;
            cmd_nx = rw_cmd;
        end
        if (st[S_ISSUE] && grant)
            st_nx = 4'b1 << S_IDLE;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= 4'b1 << S_IDLE;
            row_open <= 1'b0;
            cnt      <= 3'd0;
            valid_q  <= 1'b0;
            cmd_q    <= CMD_NOP;
        end else begin
            st <= st_nx;
            if (load) begin
                valid_q <= 1'b1;
                cmd_q   <= cmd_nx;
            end else if (grant) begin
                valid_q <= 1'b0;   // hold until granted
            end
            if (grant && cmd_q == CMD_PRECHARGE) begin
                row_open <= 1'b0;
                cnt      <= 3'(T_RP - 1);
            end else if (grant && cmd_q == CMD_ACTIVE) begin
                row_open <= 1'b1;
                cnt      <= 3'(T_RCD - 1);
            end else if (cnt != 3'd0) begin
                cnt <= cnt - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            // a10 low on column commands, no auto precharge
            if (cmd_nx == CMD_ACTIVE)
                a_q <= breq.row;
            else if (cmd_nx == CMD_PRECHARGE)
                a_q <= '0;         // a10 low, this bank only
            else
                a_q <= {{(ROW_W - COL_W){1'b0}}, breq.col};
            is_rd_q <= breq.rd;
            wdata_q <= breq.wdata;
        end
        if (grant && cmd_q == CMD_ACTIVE)
            open_row <= a_q;
    end

    assign bcmd = '{valid: valid_q, cmd: cmd_q, a: a_q, is_rd: is_rd_q, wdata: wdata_q};

    a_col_needs_row: assert property (@(posedge clk) disable iff (rst)
        valid_q && (cmd_q == CMD_READ || cmd_q == CMD_WRITE) |-> row_open);

    a_grant_valid: assert property (@(posedge clk) disable iff (rst)
        grant |-> valid_q);

endmodule

// ==== hdl/sdram_req_decode.sv ====
`timescale 1ns/1ps

module sdram_req_decode import sdram_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  client_req_t req,
    input  logic        accept,   // bank took the READ/WRITE
    output bank_req_t   breq
);

    logic             rd_q, wr_q;   // pending flags
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    logic [DW-1:0]    wdata_q;
    logic             pend;
    logic             load;

    assign pend = rd_q | wr_q;
    // only take a new request once the old one is gone
    assign load = !pend && (req.rd || req.wr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (load) begin
            rd_q <= req.rd;
            wr_q <= req.wr;
        end else if (accept) begin   // client still holds rd/wr this cycle
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            row_q   <= req.addr[COL_W +: ROW_W];  // bank bits dropped
            col_q   <= req.addr[COL_W-1:0];
            wdata_q <= req.wdata;
        end
    end

    assign breq = '{rd: rd_q, wr: wr_q, row: row_q, col: col_q, wdata: wdata_q};

    // client keeps the same request up until ack
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        pend && !accept |-> (req.rd == rd_q && req.wr == wr_q));

endmodule

// ==== hdl/sdram_pkg.sv ====
package sdram_pkg;

    // geometry
    localparam int NBANK  = 4;
    localparam int BA_W   = 2;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int ADDR_W = BA_W + ROW_W + COL_W;  // bank, row, column
    localparam int DW     = 16;
    localparam int BURST  = 4;     // read burst length in words

    // timing in clock cycles
    localparam int T_RCD   = 2;
    localparam int T_RP    = 2;
    localparam int T_RRD   = 2;
    localparam int CAS_LAT = 2;

    // dq bus bookkeeping in the arbiter
    localparam int DQ_HOLD   = CAS_LAT + BURST;  // bus busy after a READ
    localparam int RD_REOPEN = CAS_LAT + 1;      // next READ may go once count drops here

    // read path delay, CAS latency plus the dq input register
    localparam int RD_PIPE = CAS_LAT + 1;

    // bank fsm one-hot bit positions
    localparam int S_IDLE  = 0;
    localparam int S_PRE   = 1;
    localparam int S_ACT   = 2;
    localparam int S_ISSUE = 3;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010
    } sdram_cmd_e;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;   // {bank, row, col}
        logic [DW-1:0]     wdata;
    } client_req_t;

    typedef struct packed {
        logic             rd;
        logic             wr;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [DW-1:0]    wdata;
    } bank_req_t;

    typedef struct packed {
        logic             valid;
        sdram_cmd_e       cmd;
        logic [ROW_W-1:0] a;
        logic             is_rd;
        logic [DW-1:0]    wdata;
    } bank_cmd_t;

    typedef struct packed {
        sdram_cmd_e       cmd;
        logic [BA_W-1:0]  ba;
        logic [ROW_W-1:0] a;
        logic [DW-1:0]    dq_out;
        logic             dq_oe;
    } sdram_pins_t;

endpackage
